// File: src/video_pkg.sv
package video_pkg;

    // ====================
    // basic scalar types
    typedef logic [15:0] coord_t;   // pixel / line coordinate
    typedef logic [9:0]  cam_raw_t; // one RAW10 camera sample

    // ====================
    // sync and pixel structs
    typedef struct packed {
        logic vs; // vertical sync, active high
        logic hs; // horizontal sync, active high
        logic de; // active video
    } video_sync_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        video_sync_t sync;
        rgb565_t     rgb;
    } pix565_t; // 19 bits

    typedef struct packed {
        video_sync_t sync;
        rgb888_t     rgb;
    } pix888_t; // 27 bits

    typedef enum logic [1:0] {
        BARS  = 2'd0,
        GRID  = 2'd1,
        RAMP  = 2'd2,
        SOLID = 2'd3
    } pattern_mode_e;

    // ====================
    // constants
    localparam rgb888_t BLANK_RGB = '{r: 8'h00, g: 8'h00, b: 8'hff}; // blue outside de
    localparam rgb888_t SOLID_RGB = '{r: 8'h00, g: 8'hff, b: 8'h00}; // single color green

    localparam rgb888_t BAR_COLORS [8] = '{
        '{r: 8'hff, g: 8'hff, b: 8'hff}, // white
        '{r: 8'hff, g: 8'hff, b: 8'h00}, // yellow
        '{r: 8'h00, g: 8'hff, b: 8'hff}, // cyan
        '{r: 8'h00, g: 8'hff, b: 8'h00}, // green
        '{r: 8'hff, g: 8'h00, b: 8'hff}, // magenta
        '{r: 8'hff, g: 8'h00, b: 8'h00}, // red
        '{r: 8'h00, g: 8'h00, b: 8'hff}, // blue
        '{r: 8'h00, g: 8'h00, b: 8'h00}  // black
    };

    localparam int MODE_FRAMES_LOG2 = 6;    // 64 frames per mode
    localparam int FRAME_CNT_MAX    = 1023; // frame count saturates here

endpackage

// File: src/key_toggle_fsm.sv
`timescale 1ns/1ps

module key_toggle_fsm #(
    parameter int DEBOUNCE_CYCLES = 540000
) (
    input  logic I_clk,
    input  logic sys_resetn,
    input  logic key,        // push key, active low
    output logic source_sel  // 1 = pattern, 0 = camera
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic {
        RELEASED = 1'b0,
        HELD     = 1'b1
    } key_state_e;

    key_state_e       state;
    logic             key_in;   // sampled key, active high
    logic [CNT_W-1:0] hold_cnt; // sampled cycles held so far
    logic             hold_hit;

    // last sample of the hold window
    assign hold_hit = (hold_cnt == CNT_W'(DEBOUNCE_CYCLES - 1));

    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            key_in <= 1'b0;
        end else begin
            key_in <= ~key; // invert to active high
        end
    end

    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            state      <= RELEASED;
            hold_cnt   <= '0;
            source_sel <= 1'b0; // camera after reset
        end else begin
            case (state)
                RELEASED: begin
                    if (key_in) begin
                        state    <= HELD;
                        hold_cnt <= CNT_W'(1); // first held sample
                    end
                end
                HELD: begin
                    if (!key_in) begin
                        state    <= RELEASED; // any release restarts
                        hold_cnt <= '0;
                    end else if (hold_hit) begin
                        source_sel <= ~source_sel; // toggle, auto-repeat
                        hold_cnt   <= '0;
                    end else begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                default: state <= RELEASED;
            endcase
        end
    end

endmodule

// File: src/video_timing.sv
`timescale 1ns/1ps

module video_timing #(
    parameter int H_TOTAL  = 1650,
    parameter int H_SYNC   = 40,
    parameter int H_BPORCH = 220,
    parameter int H_RES    = 640,
    parameter int V_TOTAL  = 750,
    parameter int V_SYNC   = 5,
    parameter int V_BPORCH = 20,
    parameter int V_RES    = 480
) (
    input  logic                  I_clk,
    input  logic                  sys_resetn,
    output video_pkg::video_sync_t tim_sync,
    output video_pkg::coord_t      tim_x,
    output video_pkg::coord_t      tim_y
);

    import video_pkg::*;

    // active window bounds, in counter units
    localparam coord_t H_START = coord_t'(H_SYNC + H_BPORCH);
    localparam coord_t H_END   = coord_t'(H_SYNC + H_BPORCH + H_RES);
    localparam coord_t V_START = coord_t'(V_SYNC + V_BPORCH);
    localparam coord_t V_END   = coord_t'(V_SYNC + V_BPORCH + V_RES);

    coord_t hcnt;
    coord_t vcnt;
    logic   h_last;
    logic   v_last;
    logic   h_act;
    logic   v_act;

    assign h_last = (hcnt == coord_t'(H_TOTAL - 1));
    assign v_last = (vcnt == coord_t'(V_TOTAL - 1));
    assign h_act  = (hcnt >= H_START) && (hcnt < H_END);
    assign v_act  = (vcnt >= V_START) && (vcnt < V_END);

    // ====================
    // raster counters
    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            if (h_last) begin
                hcnt <= '0;
                if (v_last) begin
                    vcnt <= '0; // frame wrap
                end else begin
                    vcnt <= vcnt + 1'b1; // next line
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // ====================
    // registered sync and coordinates
    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            tim_sync <= '0;
            tim_x    <= '0;
            tim_y    <= '0;
        end else begin
            tim_sync.hs <= (hcnt < coord_t'(H_SYNC)); // positive polarity
            tim_sync.vs <= (vcnt < coord_t'(V_SYNC));
            tim_sync.de <= h_act && v_act;
            tim_x       <= hcnt - H_START; // offset in active line
            tim_y       <= vcnt - V_START; // only valid with de
        end
    end

endmodule

// File: src/pattern_gen.sv
`timescale 1ns/1ps

module pattern_gen #(
    parameter int H_RES = 640
) (
    input  logic                   I_clk,
    input  logic                   sys_resetn,
    input  video_pkg::video_sync_t tim_sync,
    input  video_pkg::coord_t      tim_x,
    input  video_pkg::coord_t      tim_y,
    output video_pkg::pix888_t     pat_pix
);

    import video_pkg::*;

    localparam int FCNT_W = $clog2(FRAME_CNT_MAX + 1);
    localparam int BAR_W  = (H_RES >= 8) ? (H_RES / 8) : 1; // pixels per bar

    logic [FCNT_W-1:0] frame_cnt;
    logic              vs_d;
    logic              vs_fall;
    pattern_mode_e     mode;
    coord_t            bar_q;
    logic [2:0]        bar_idx;
    logic              grid_line;
    rgb888_t           pat_rgb;

    assign vs_fall = vs_d && !tim_sync.vs; // end of vertical sync

    // ====================
    // frame counter and mode
    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            vs_d      <= 1'b0;
            frame_cnt <= '0;
        end else begin
            vs_d <= tim_sync.vs;
            if (vs_fall && (frame_cnt != FCNT_W'(FRAME_CNT_MAX))) begin
                frame_cnt <= frame_cnt + 1'b1; // saturating
            end
        end
    end

    assign mode = pattern_mode_e'(frame_cnt[MODE_FRAMES_LOG2 +: 2]);

    // clamp keeps blanking coordinates inside the table
    assign bar_q     = tim_x / coord_t'(BAR_W);
    assign bar_idx   = (bar_q > coord_t'(7)) ? 3'd7 : bar_q[2:0];
    assign grid_line = (tim_x[2:0] == 3'd0) || (tim_y[2:0] == 3'd0);

    always_comb begin
        case (mode)
            BARS:    pat_rgb = BAR_COLORS[bar_idx];
            GRID:    pat_rgb = grid_line ? BAR_COLORS[0] : BAR_COLORS[7]; // white / black
            RAMP:    pat_rgb = '{r: tim_x[7:0], g: tim_x[7:0], b: tim_x[7:0]};
            default: pat_rgb = SOLID_RGB;
        endcase
    end

    // ====================
    // output register, sync carried along
    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            pat_pix <= '0;
        end else begin
            pat_pix.sync <= tim_sync;
            pat_pix.rgb  <= pat_rgb;
        end
    end

endmodule

// File: src/camera_capture.sv
`timescale 1ns/1ps

module camera_capture (
    input  logic                I_clk,
    input  logic                sys_resetn,
    input  logic                cam_vsync,   // active low
    input  logic                cam_href,
    input  video_pkg::cam_raw_t cam_pixdata,
    output video_pkg::pix565_t  cam_pix
);

    // one register stage, gray expansion on the way in
    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            cam_pix <= '0;
        end else begin
            cam_pix.sync.vs <= ~cam_vsync;          // to active high
            cam_pix.sync.hs <= 1'b0;                // camera gives no hsync
            cam_pix.sync.de <= cam_href;            // line valid
            cam_pix.rgb.r   <= cam_pixdata[9:5];    // upper 5 bits
            cam_pix.rgb.g   <= cam_pixdata[9:4];    // upper 6 bits
            cam_pix.rgb.b   <= cam_pixdata[9:5];
        end
    end

endmodule

// File: src/display_formatter.sv
`timescale 1ns/1ps

module display_formatter (
    input  logic               I_clk,
    input  logic               sys_resetn,
    input  logic               source_sel,  // 1 = pattern
    input  video_pkg::pix888_t pat_pix,
    input  video_pkg::pix565_t cam_pix,
    output video_pkg::pix888_t out_pix
);

    import video_pkg::*;

    rgb565_t pat565;   // pattern reduced to 565
    pix565_t s1_pix;   // stage 1 register
    rgb888_t wide_rgb; // stage 1 widened back to 888

    assign pat565 = '{r: pat_pix.rgb.r[7:3], g: pat_pix.rgb.g[7:2], b: pat_pix.rgb.b[7:3]};

    // zero padding in the low bits
    assign wide_rgb = '{r: {s1_pix.rgb.r, 3'b000},
                        g: {s1_pix.rgb.g, 2'b00},
                        b: {s1_pix.rgb.b, 3'b000}};

    // ====================
    // stage 1, source select
    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            s1_pix <= '0;
        end else if (source_sel) begin
            s1_pix <= '{sync: pat_pix.sync, rgb: pat565};
        end else begin
            s1_pix <= cam_pix;
        end
    end

    // ====================
    // stage 2, widen and blank
    always_ff @(posedge I_clk or negedge sys_resetn) begin
        if (!sys_resetn) begin
            out_pix <= '{sync: '0, rgb: BLANK_RGB};
        end else begin
            out_pix.sync <= s1_pix.sync; // sync follows data
            out_pix.rgb  <= s1_pix.sync.de ? wide_rgb : BLANK_RGB;
        end
    end

endmodule

// File: src/video_top.sv
`timescale 1ns/1ps

module video_top #(
    parameter int H_TOTAL         = 1650,
    parameter int H_SYNC          = 40,
    parameter int H_BPORCH        = 220,
    parameter int H_RES           = 640,
    parameter int V_TOTAL         = 750,
    parameter int V_SYNC          = 5,
    parameter int V_BPORCH        = 20,
    parameter int V_RES           = 480,
    parameter int DEBOUNCE_CYCLES = 540000
) (
    input  logic                I_clk,
    input  logic                sys_resetn,
    input  logic                key,          // active low
    input  logic                cam_vsync,
    input  logic                cam_href,
    input  video_pkg::cam_raw_t cam_pixdata,
    output video_pkg::pix888_t  out_pix,
    output logic                led
);

    import video_pkg::*;

    video_sync_t tim_sync;
    coord_t      tim_x;
    coord_t      tim_y;
    pix888_t     pat_pix;
    pix565_t     cam_pix;
    logic        source_sel;

    assign led = source_sel; // lit while pattern selected

    // ====================
    key_toggle_fsm #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) key_toggle_fsm_i (
        .I_clk      (I_clk),
        .sys_resetn (sys_resetn),
        .key        (key),
        .source_sel (source_sel)
    );

    video_timing #(
        .H_TOTAL  (H_TOTAL),
        .H_SYNC   (H_SYNC),
        .H_BPORCH (H_BPORCH),
        .H_RES    (H_RES),
        .V_TOTAL  (V_TOTAL),
        .V_SYNC   (V_SYNC),
        .V_BPORCH (V_BPORCH),
        .V_RES    (V_RES)
    ) video_timing_i (
        .I_clk      (I_clk),
        .sys_resetn (sys_resetn),
        .tim_sync   (tim_sync),
        .tim_x      (tim_x),
        .tim_y      (tim_y)
    );

    pattern_gen #(
        .H_RES (H_RES)
    ) pattern_gen_i (
        .I_clk      (I_clk),
        .sys_resetn (sys_resetn),
        .tim_sync   (tim_sync),
        .tim_x      (tim_x),
        .tim_y      (tim_y),
        .pat_pix    (pat_pix)
    );

    camera_capture camera_capture_i (
        .I_clk       (I_clk),
        .sys_resetn  (sys_resetn),
        .cam_vsync   (cam_vsync),
        .cam_href    (cam_href),
        .cam_pixdata (cam_pixdata),
        .cam_pix     (cam_pix)
    );

    display_formatter display_formatter_i (
        .I_clk      (I_clk),
        .sys_resetn (sys_resetn),
        .source_sel (source_sel),
        .pat_pix    (pat_pix),
        .cam_pix    (cam_pix),
        .out_pix    (out_pix)
    );

endmodule

// File: verification/video_top_checker.sv
`timescale 1ns/1ps

module video_top_checker (
    input logic               I_clk,
    input logic               sys_resetn,
    input logic               source_sel,
    input video_pkg::pix888_t pat_pix,
    input video_pkg::pix565_t cam_pix,
    input video_pkg::pix888_t out_pix
);

    import video_pkg::*;

    // ====================
    // output pixel rules
    assert property (@(posedge I_clk) disable iff (!sys_resetn)
        !out_pix.sync.de |-> (out_pix.rgb == BLANK_RGB)) // blue in blanking
        else $error("rgb is not blue while de is low");

    assert property (@(posedge I_clk) disable iff (!sys_resetn)
        out_pix.sync.de |-> (out_pix.rgb.r[2:0] == 3'b000 &&
                             out_pix.rgb.g[1:0] == 2'b00  &&
                             out_pix.rgb.b[2:0] == 3'b000)) // 565 pad bits
        else $error("zero pad bits of rgb are set while de is high");

    assert property (@(posedge I_clk) disable iff (!sys_resetn)
        out_pix.sync == ($past(source_sel, 2) ? $past(pat_pix.sync, 2)
                                              : $past(cam_pix.sync, 2))) // two stages
        else $error("out_pix sync is not two cycles behind the selected source");

endmodule

bind display_formatter video_top_checker video_top_checker_i (
    .I_clk      (I_clk),
    .sys_resetn (sys_resetn),
    .source_sel (source_sel),
    .pat_pix    (pat_pix),
    .cam_pix    (cam_pix),
    .out_pix    (out_pix)
);

// File: verification/video_top_tb.sv
`timescale 1ns/1ps

module video_top_tb;

    import video_pkg::*;

    localparam int H_TOTAL   = 40;
    localparam int H_SYNC    = 4;
    localparam int H_BPORCH  = 6;
    localparam int H_RES     = 24;
    localparam int V_TOTAL   = 12;
    localparam int V_SYNC    = 2;
    localparam int V_BPORCH  = 2;
    localparam int V_RES     = 6;
    localparam int DEBOUNCE  = 8;
    localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
    localparam int FALL_POS  = V_SYNC * H_TOTAL;  // raster position where vs drops
    localparam rgb888_t BLUE  = rgb888_t'(24'h0000ff);
    localparam rgb888_t GREEN = rgb888_t'(24'h00ff00);

    typedef struct packed {
        logic     vsync;
        logic     href;
        cam_raw_t data;
        logic     valid; // sampled out of reset
    } cam_in_t;

    logic     I_clk;
    logic     sys_resetn;
    logic     key;
    logic     cam_vsync;
    logic     cam_href;
    cam_raw_t cam_pixdata;
    pix888_t  out_pix;
    logic     led;

    logic    stim_on    = 1'b0; // random camera stream running
    logic    model_live = 1'b0;
    int      cyc;                // rising edges since reset release
    logic    key_in_m;           // model of the key sampler
    int      run_cnt;            // consecutive held samples
    logic    sel_m;
    logic    sel_hist [3];       // [k] = select k edges ago
    cam_in_t cam_hist [3];
    int      mode_hits [4] = '{0, 0, 0, 0};

    video_top #(
        .H_TOTAL (H_TOTAL), .H_SYNC (H_SYNC), .H_BPORCH (H_BPORCH), .H_RES (H_RES),
        .V_TOTAL (V_TOTAL), .V_SYNC (V_SYNC), .V_BPORCH (V_BPORCH), .V_RES (V_RES),
        .DEBOUNCE_CYCLES (DEBOUNCE)
    ) video_top_i (
        .I_clk       (I_clk),
        .sys_resetn  (sys_resetn),
        .key         (key),
        .cam_vsync   (cam_vsync),
        .cam_href    (cam_href),
        .cam_pixdata (cam_pixdata),
        .out_pix     (out_pix),
        .led         (led)
    );

    initial begin
        I_clk = 1'b0;
        forever #2 I_clk = ~I_clk; // 4 ns period
    end

    // ====================
    // reference model
    function automatic int frame_mode(input int pos);
        int fcnt;
        fcnt = 0;
        if (pos > FALL_POS) fcnt = (pos - FALL_POS - 1) / FRAME_LEN + 1; // falls already seen
        if (fcnt > 1023) fcnt = 1023;   // saturation
        return (fcnt >> 6) % 4;         // 64 frames per mode
    endfunction

    function automatic rgb888_t bar_color(input int idx);
        case (idx)
            0:       return rgb888_t'(24'hffffff); // white
            1:       return rgb888_t'(24'hffff00); // yellow
            2:       return rgb888_t'(24'h00ffff); // cyan
            3:       return rgb888_t'(24'h00ff00); // green
            4:       return rgb888_t'(24'hff00ff); // magenta
            5:       return rgb888_t'(24'hff0000); // red
            6:       return rgb888_t'(24'h0000ff); // blue
            default: return rgb888_t'(24'h000000); // black
        endcase
    endfunction

    function automatic rgb888_t pattern_rgb(input int mode, input int x, input int y);
        int idx;
        idx = x / (H_RES / 8);
        if (idx > 7) idx = 7;
        case (mode)
            0:       return bar_color(idx);
            1:       return ((x % 8 == 0) || (y % 8 == 0)) ? bar_color(0) : bar_color(7);
            2:       return rgb888_t'({3{x[7:0]}}); // gray ramp
            default: return GREEN;
        endcase
    endfunction

    function automatic pix888_t expected_pix(input logic sel, input cam_in_t cam, input int pos);
        pix888_t e;
        rgb888_t c;
        int      h;
        int      v;
        e = '{sync: '0, rgb: BLUE};                     // reset / blanking value
        if (!sel && cam.valid) begin
            e.sync.vs = ~cam.vsync;
            e.sync.de = cam.href;
            if (cam.href) begin
                e.rgb = '{r: {cam.data[9:5], 3'b000}, g: {cam.data[9:4], 2'b00},
                          b: {cam.data[9:5], 3'b000}};
            end
        end else if (sel && pos >= 0) begin
            h = (pos % FRAME_LEN) % H_TOTAL;
            v = (pos % FRAME_LEN) / H_TOTAL;
            e.sync.hs = (h < H_SYNC);
            e.sync.vs = (v < V_SYNC);
            e.sync.de = (h >= H_SYNC + H_BPORCH) && (h < H_SYNC + H_BPORCH + H_RES) &&
                        (v >= V_SYNC + V_BPORCH) && (v < V_SYNC + V_BPORCH + V_RES);
            if (e.sync.de) begin
                c = pattern_rgb(frame_mode(pos), h - H_SYNC - H_BPORCH, v - V_SYNC - V_BPORCH);
                e.rgb = '{r: c.r & 8'hf8, g: c.g & 8'hfc, b: c.b & 8'hf8}; // via 565
            end
        end
        return e;
    endfunction

    // same edge the DUT samples on, so inputs read here are the sampled ones
    always @(posedge I_clk) begin
        model_live = 1'b1;
        if (!sys_resetn) begin
            cyc         = 0;
            key_in_m    = 1'b0;
            run_cnt     = 0;
            sel_m       = 1'b0;
            sel_hist    = '{1'b0, 1'b0, 1'b0};
            cam_hist[0] = '0;
            cam_hist[1] = '0;
            cam_hist[2] = '0;
        end else begin
            cyc = cyc + 1;
            if (key_in_m) begin
                run_cnt = run_cnt + 1;
                if (run_cnt == DEBOUNCE) begin // full hold window, toggle and repeat
                    sel_m   = ~sel_m;
                    run_cnt = 0;
                end
            end else begin
                run_cnt = 0;                   // release restarts
            end
            key_in_m    = ~key;
            sel_hist[2] = sel_hist[1];
            sel_hist[1] = sel_hist[0];
            sel_hist[0] = sel_m;
            cam_hist[2] = cam_hist[1];
            cam_hist[1] = cam_hist[0];
            cam_hist[0] = '{vsync: cam_vsync, href: cam_href, data: cam_pixdata, valid: 1'b1};
        end
    end

    // ====================
    // checks
    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_pix888(input pix888_t got, input pix888_t exp);
        if (got !== exp) begin
            $display("** Error: out_pix = %h, expected %h (cycle %0d)", got, exp, cyc);
            stop_run();
        end
    endtask

    task automatic check_led(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: led = %h, expected %h (cycle %0d)", got, exp, cyc);
            stop_run();
        end
    endtask

    initial begin
        pix888_t    exp_pix;
        logic [1:0] m;
        forever begin
            @(negedge I_clk);                  // outputs settled
            if (model_live) begin
                exp_pix = expected_pix(sel_hist[2], cam_hist[2], cyc - 4);
                check_pix888(out_pix, exp_pix);
                check_led(led, sel_hist[0]);
                if (sel_hist[2] && exp_pix.sync.de) begin
                    m = 2'(frame_mode(cyc - 4));
                    mode_hits[m] = mode_hits[m] + 1; // active pixels seen per mode
                end
            end
        end
    end

    // ====================
    // stimulus
    always @(posedge I_clk) begin : cam_drive
        logic [31:0] rnd;
        if (stim_on) begin
            rnd = $urandom;
            cam_pixdata <= cam_raw_t'($urandom);
            cam_href    <= rnd[0];
            cam_vsync   <= (rnd[7:4] != 4'h0); // mostly high, active low
        end
    end

    task automatic press_key(input int hold);
        @(posedge I_clk);
        key <= 1'b0;
        repeat (hold) @(posedge I_clk);
        key <= 1'b1;
    endtask

    task automatic wait_led(input logic value, input int limit);
        int t;
        t = 0;
        while (led !== value && t < limit) begin
            @(negedge I_clk);
            t = t + 1;
        end
        if (led !== value) begin
            $display("timeout: led did not change to %0b within %0d cycles", value, limit);
            stop_run();
        end
    endtask

    task automatic wait_frames(input int count);
        int   seen;
        int   t;
        logic vs_prev;
        seen    = 0;
        t       = 0;
        vs_prev = out_pix.sync.vs;
        while (seen < count && t < (count + 1) * FRAME_LEN) begin
            @(negedge I_clk);
            if (vs_prev && !out_pix.sync.vs) seen = seen + 1; // end of vsync
            vs_prev = out_pix.sync.vs;
            t = t + 1;
        end
        if (seen < count) begin
            $display("timeout: only %0d of %0d frames seen on out_pix", seen, count);
            stop_run();
        end
    endtask

    initial begin
        void'($urandom(32'h1e0b195a));
        sys_resetn  = 1'b0;
        key         = 1'b1;
        cam_vsync   = 1'b1;
        cam_href    = 1'b0;
        cam_pixdata = '0;
        repeat (9) @(posedge I_clk);
        @(negedge I_clk);
        check_led(led, 1'b0);                           // reset state
        check_pix888(out_pix, '{sync: '0, rgb: BLUE});
        @(posedge I_clk);
        sys_resetn <= 1'b1;
        stim_on    <= 1'b1;
        repeat (36) @(posedge I_clk);                   // camera stream
        press_key(5);                                   // glitch, too short
        repeat (4) @(posedge I_clk);
        @(negedge I_clk);
        check_led(led, 1'b0);
        press_key(10);                                  // done before first vs fall
        wait_led(1'b1, 20);
        wait_frames(200);                               // all four patterns
        press_key(10);
        wait_led(1'b0, 20);
        repeat (300) @(posedge I_clk);                  // camera again
        @(negedge I_clk);
        if (mode_hits[0] > 0 && mode_hits[1] > 0 && mode_hits[2] > 0 && mode_hits[3] > 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("pattern mode was not reached in every mode: %0d %0d %0d %0d",
                     mode_hits[0], mode_hits[1], mode_hits[2], mode_hits[3]);
            stop_run();
        end
    end

endmodule

// File: list.f
src/video_pkg.sv
src/key_toggle_fsm.sv
src/video_timing.sv
src/pattern_gen.sv
src/camera_capture.sv
src/display_formatter.sv
src/video_top.sv
verification/video_top_checker.sv
verification/video_top_tb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f list.f --top-module video_top_tb -Mdir obj_dir -o video_top_sim
	@out="$$(./obj_dir/video_top_sim)"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
